/* all.f */
+incdir+tests
src/core_pkg.sv
src/rom_loader.sv
src/video_timing.sv
src/pixel_fetch.sv
src/video_out.sv
src/core_top.sv
tests/core_tb.sv

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // raster geometry, counted in pixel clock enables
    localparam int h_total   = 32;
    localparam int h_visible = 24;
    localparam int v_total   = 20;
    localparam int v_visible = 16;

    // one rom byte per visible pixel
    localparam int rom_len = h_visible * v_visible;
    localparam int rom_aw  = $clog2(rom_len);

    // ioctl address bus width, as on the download port
    localparam int addr_w = 25;

    // raster position, both counters fit in five bits
    typedef struct packed {
        logic [4:0] h;
        logic [4:0] v;
    } pos_t;

    // write accepted by the loader, already range checked
    typedef struct packed {
        logic              valid;
        logic [rom_aw-1:0] addr;
        logic [7:0]        data;
    } rom_write_t;

    // pixel as it leaves the core, blanking travels with color
    typedef struct packed {
        logic       hb;
        logic       vb;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } video_t;

endpackage

`default_nettype wire

/* src/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              downloading,
    input  logic              ioctl_wr,
    input  logic [addr_w-1:0] ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    output logic              pxl_cen,
    output video_t            video,
    output logic [31:0]       frame_cnt,
    output logic              led
);

    rom_write_t rom_write;
    logic       loaded;
    pos_t       pos;
    logic       hb;
    logic       vb;
    logic [7:0] pixel;

    rom_loader u_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .rom_write   ( rom_write   ),
        .loaded      ( loaded      )
    );

    video_timing u_timing (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .pos     ( pos     ),
        .hb      ( hb      ),
        .vb      ( vb      )
    );

    pixel_fetch u_fetch (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .pos       ( pos       ),
        .rom_write ( rom_write ),
        .loaded    ( loaded    ),
        .pixel     ( pixel     )
    );

    // raw blanking goes here, video_out aligns it with the pixel
    video_out u_out (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .hb        ( hb        ),
        .vb        ( vb        ),
        .pixel     ( pixel     ),
        .loaded    ( loaded    ),
        .video     ( video     ),
        .frame_cnt ( frame_cnt ),
        .led       ( led       )
    );

endmodule

`default_nettype wire

/* src/pixel_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pxl_cen,
    input  pos_t       pos,
    input  rom_write_t rom_write,
    input  logic       loaded,
    output logic [7:0] pixel
);

    logic [7:0]        mem [0:rom_len-1];
    logic              visible;
    logic [rom_aw-1:0] rd_addr;

    // pattern ram, filled straight from the loader
    always_ff @(posedge clk) begin
        if (rom_write.valid) begin
            mem[rom_write.addr] <= rom_write.data;
        end
    end

    assign visible = (pos.h < 5'(h_visible)) && (pos.v < 5'(v_visible));

    // row major, one byte per visible pixel
    assign rd_addr = rom_aw'(pos.v * h_visible + pos.h);

    // read is only done for visible positions so rd_addr stays in range
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel <= 8'h00;
        end else if (pxl_cen) begin
            if (visible && loaded) begin
                pixel <= mem[rd_addr];
            end else begin
                pixel <= 8'h00;
            end
        end
    end

    // loader filtering keeps every ram write inside the image
    ram_write_in_range: assert property (
        @(posedge clk) disable iff (reset)
        rom_write.valid |-> (rom_write.addr < rom_aw'(rom_len))
    ) else $error("pattern ram write outside the image");

endmodule

`default_nettype wire

/* src/rom_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_loader import core_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              downloading,
    input  logic              ioctl_wr,
    input  logic [addr_w-1:0] ioctl_addr,
    input  logic [7:0]        ioctl_dout,
    output rom_write_t        rom_write,
    output logic              loaded
);

    logic              dl_prev;
    logic              dl_rise;
    logic              dl_fall;
    logic              accept;
    logic [rom_aw-1:0] cnt;
    logic [rom_aw-1:0] cnt_base;

    assign dl_rise = downloading && !dl_prev;
    assign dl_fall = !downloading && dl_prev;

    // only bytes inside the image reach the pattern ram
    assign accept = ioctl_wr && downloading && (ioctl_addr < addr_w'(rom_len));

    // a new download starts counting from zero, even on its first cycle
    assign cnt_base = dl_rise ? '0 : cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            rom_write.valid <= 1'b0;
        end else begin
            rom_write.valid <= accept;
            rom_write.addr  <= ioctl_addr[rom_aw-1:0];
            rom_write.data  <= ioctl_dout;
        end
    end

    // counter only moves when the address matches the running count,
    // so repeated or out of order bytes do not inflate it
    always_ff @(posedge clk) begin
        if (reset) begin
            dl_prev <= 1'b0;
            cnt     <= '0;
            loaded  <= 1'b0;
        end else begin
            dl_prev <= downloading;
            if (accept && ioctl_addr == addr_w'(cnt_base)) begin
                cnt <= cnt_base + 1'b1;
            end else begin
                cnt <= cnt_base;
            end
            if (dl_rise) begin
                loaded <= 1'b0;
            end else if (dl_fall) begin
                loaded <= (cnt == rom_aw'(rom_len));
            end
        end
    end

    // the download port only strobes inside a download window
    wr_inside_download: assert property (
        @(posedge clk) disable iff (reset)
        ioctl_wr |-> downloading
    ) else $error("ioctl_wr seen while downloading is low");

endmodule

`default_nettype wire

/* src/video_out.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        pxl_cen,
    input  logic        hb,
    input  logic        vb,
    input  logic [7:0]  pixel,
    input  logic        loaded,
    output video_t      video,
    output logic [31:0] frame_cnt,
    output logic        led
);

    logic hb_d;
    logic vb_d;
    logic vb_rise;

    // video.vb goes high on this edge
    assign vb_rise = pxl_cen && vb_d && !video.vb;

    // blanking waits one pxl_cen step for the fetched byte, then both register together
    always_ff @(posedge clk) begin
        if (reset) begin
            hb_d        <= 1'b1;
            vb_d        <= 1'b1;
            video.hb    <= 1'b1;
            video.vb    <= 1'b1;
            video.red   <= 4'h0;
            video.green <= 4'h0;
            video.blue  <= 4'h0;
        end else if (pxl_cen) begin
            hb_d        <= hb;
            vb_d        <= vb;
            video.hb    <= hb_d;
            video.vb    <= vb_d;
            video.red   <= pixel[3:0];
            video.green <= pixel[7:4];
            video.blue  <= {pixel[7:6], pixel[1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt <= 32'd0;
        end else if (vb_rise) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    // busy led, low until a full image is in
    always_ff @(posedge clk) begin
        if (reset) begin
            led <= 1'b0;
        end else begin
            led <= loaded;
        end
    end

    // the fetch must zero blanked positions in step with this delay
    black_in_blank: assert property (
        @(posedge clk) disable iff (reset)
        (video.hb || video.vb) |-> ({video.red, video.green, video.blue} == '0)
    ) else $error("color output during blanking");

endmodule

`default_nettype wire

/* src/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing import core_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic pxl_cen,
    output pos_t pos,
    output logic hb,
    output logic vb
);

    logic cen_div;
    logic line_end;
    logic frame_end;

    // divide by two, pxl_cen is the registered phase of the divider
    always_ff @(posedge clk) begin
        if (reset) begin
            cen_div <= 1'b0;
            pxl_cen <= 1'b0;
        end else begin
            cen_div <= ~cen_div;
            pxl_cen <= cen_div;
        end
    end

    assign line_end  = (pos.h == 5'(h_total - 1));
    assign frame_end = (pos.v == 5'(v_total - 1));

    // position counters, frame starts at the top left visible pixel
    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                pos.h <= '0;
                if (frame_end) begin
                    pos.v <= '0;
                end else begin
                    pos.v <= pos.v + 1'b1;
                end
            end else begin
                pos.h <= pos.h + 1'b1;
            end
        end
    end

    // blanking lines up with pos, video_out adds the fetch delay
    assign hb = (pos.h >= 5'(h_visible));
    assign vb = (pos.v >= 5'(v_visible));

    // half rate enable, never two in a row
    cen_half_rate: assert property (
        @(posedge clk) disable iff (reset)
        pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high on consecutive clocks");

endmodule

`default_nettype wire

/* tests/core_checks.svh */
`ifndef core_checks_svh
`define core_checks_svh

// pixel compare, where names the raster position
task automatic check_video(input string where, input video_t got, input video_t exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        n_errors = n_errors + 1;
        $display("FAILED %0t ns: video %s got %h expected %h", $time, where, got, exp);
    end
endtask

task automatic check_count(input logic [31:0] got, input logic [31:0] exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        n_errors = n_errors + 1;
        $display("FAILED %0t ns: frame_cnt got %0d expected %0d", $time, got, exp);
    end
endtask

task automatic check_led(input logic got, input logic exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        n_errors = n_errors + 1;
        $display("FAILED %0t ns: led got %b expected %b", $time, got, exp);
    end
endtask

task automatic check_cen(input logic got, input logic exp);
    n_checks = n_checks + 1;
    if (got !== exp) begin
        n_errors = n_errors + 1;
        $display("FAILED %0t ns: pxl_cen got %b expected %b", $time, got, exp);
    end
endtask

// returns on the falling clock edge where video.vb is first seen high
task automatic wait_vb_rise(output bit ok);
    int   n;
    logic prev;
    ok = 1'b0;
    n = 0;
    @(negedge clk);
    prev = video.vb;
    while (!ok && n < wait_limit) begin
        @(negedge clk);
        if (video.vb && !prev) begin
            ok = 1'b1;
        end
        prev = video.vb;
        n = n + 1;
    end
    if (!ok) begin
        n_errors = n_errors + 1;
        $display("timeout at %0t ns: vb did not rise within %0d clocks", $time, wait_limit);
    end
endtask

task automatic wait_led(input logic level, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < 100) begin
        @(negedge clk);
        ok = (led === level);
        n = n + 1;
    end
    if (!ok) begin
        n_errors = n_errors + 1;
        $display("timeout at %0t ns: led did not go to %b within 100 clocks", $time, level);
    end
endtask

`endif

/* tests/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*;;

    // two full frames of clocks, a frame is h_total * v_total steps of two clocks
    localparam int wait_limit = 4 * h_total * v_total;

    logic              clk;
    logic              reset;
    logic              downloading;
    logic              ioctl_wr;
    logic [addr_w-1:0] ioctl_addr;
    logic [7:0]        ioctl_dout;
    logic              pxl_cen;
    video_t            video;
    logic [31:0]       frame_cnt;
    logic              led;

    integer     seed;
    logic [7:0] model [0:rom_len-1];
    bit         model_loaded;
    int         dl_count;
    int         vb_rises;
    logic       vb_last;
    int         n_checks;
    int         n_errors;
    int         n_tests;
    int         test_errors;

    `include "core_checks.svh"

    core_top dut (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .pxl_cen     ( pxl_cen     ),
        .video       ( video       ),
        .frame_cnt   ( frame_cnt   ),
        .led         ( led         )
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // rising edges of video.vb since reset, each one steps frame_cnt
    always @(negedge clk) begin
        if (reset) begin
            vb_rises = 0;
            vb_last  = 1'b1;
        end else begin
            if (video.vb && !vb_last) begin
                vb_rises = vb_rises + 1;
            end
            vb_last = video.vb;
        end
    end

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            step();
        end
    endtask

    // color mapping of the model byte at image index idx
    function automatic video_t expected_pixel(input int idx);
        logic [7:0] b;
        video_t     v;
        b = model_loaded ? model[idx] : 8'h00;
        v.hb    = 1'b0;
        v.vb    = 1'b0;
        // red low nibble, green high nibble, blue top two bits over bottom two
        v.red   = 4'(b % 16);
        v.green = 4'(b / 16);
        v.blue  = 4'((b / 64) * 4 + b % 4);
        return v;
    endfunction

    // one strobe, the model takes the byte and follows the in-order count
    task automatic write_byte(input logic [addr_w-1:0] addr, input logic [7:0] data);
        ioctl_wr   = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = data;
        if (addr < rom_len) begin
            model[addr] = data;
            if (addr == dl_count) begin
                dl_count = dl_count + 1;
            end
        end
        step();
        ioctl_wr = 1'b0;
        if ($random(seed) & 1) begin
            step();
        end
    endtask

    task automatic download(input int len, input bit with_junk);
        int                a;
        bit                ok;
        logic [7:0]        d;
        logic [addr_w-1:0] junk;
        step();
        downloading  = 1'b1;
        model_loaded = 1'b0;
        dl_count     = 0;
        // a new download clears the image flag right away
        wait_led(1'b0, ok);
        step();
        if (with_junk) begin
            write_byte(addr_w'(rom_len), 8'hff);
        end
        for (a = 0; a < len; a = a + 1) begin
            if (with_junk && ($random(seed) & 3) == 0) begin
                junk = rom_len + ({$random(seed)} % 4096);
                d = $random(seed);
                write_byte(junk, d);
            end
            d = $random(seed);
            write_byte(addr_w'(a), d);
        end
        downloading  = 1'b0;
        model_loaded = (dl_count == rom_len);
    endtask

    // checks every visible pixel of the next full frame against the model
    task automatic check_frame();
        int     idx;
        int     n;
        bit     ok;
        video_t exp;
        wait_vb_rise(ok);
        idx = 0;
        n = 0;
        while (ok && idx < rom_len && n < wait_limit) begin
            @(negedge clk);
            n = n + 1;
            if (pxl_cen && !video.hb && !video.vb) begin
                exp = expected_pixel(idx);
                check_video($sformatf("(%0d,%0d)", idx % h_visible, idx / h_visible),
                            video, exp);
                idx = idx + 1;
            end
        end
        if (ok && idx < rom_len) begin
            n_errors = n_errors + 1;
            $display("timeout at %0t ns: only %0d visible pixels seen in a frame", $time, idx);
        end
    endtask

    task automatic start_test();
        test_errors = n_errors;
        n_tests = n_tests + 1;
    endtask

    task automatic finish_test(input string name);
        if (n_errors == test_errors) begin
            $display("test %0d %s: pass", n_tests, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", n_tests, name, n_errors - test_errors);
        end
    endtask

    initial begin
        bit          ok;
        int          i;
        seed         = 70;
        reset        = 1'b1;
        downloading  = 1'b0;
        ioctl_wr     = 1'b0;
        ioctl_addr   = '0;
        ioctl_dout   = 8'h00;
        model_loaded = 1'b0;
        dl_count     = 0;
        n_checks     = 0;
        n_errors     = 0;
        n_tests      = 0;
        repeat (3) begin
            @(posedge clk);
        end
        #2;
        reset = 1'b0;

        start_test();
        // first enable two clocks after reset release, then every second clock
        for (i = 0; i < 8; i = i + 1) begin
            step();
            check_cen(pxl_cen, 1'(i % 2));
        end
        check_led(led, 1'b0);
        check_count(frame_cnt, 32'd0);
        check_frame();
        finish_test("reset state");

        start_test();
        download(rom_len, 1'b0);
        idle_cycles(2);
        check_led(led, 1'b1);
        check_frame();
        finish_test("full download");

        start_test();
        download(rom_len / 2, 1'b0);
        idle_cycles(8);
        check_led(led, 1'b0);
        check_frame();
        finish_test("short download");

        start_test();
        download(rom_len, 1'b1);
        idle_cycles(2);
        check_led(led, 1'b1);
        check_frame();
        finish_test("out of range writes");

        start_test();
        for (i = 0; i < 3; i = i + 1) begin
            wait_vb_rise(ok);
            step();
            check_count(frame_cnt, 32'(vb_rises));
        end
        finish_test("frame counter");

        start_test();
        download(rom_len, 1'b0);
        idle_cycles(2);
        check_led(led, 1'b1);
        check_frame();
        finish_test("second download");

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // backstop in case a wait loop itself stalls
    initial begin
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
